// File: painter_config.svh
`ifndef PAINTER_CONFIG_SVH
`define PAINTER_CONFIG_SVH

// Framebuffer coordinate widths, 160 by 120 pixels
`define PAINT_X_WIDTH 8
`define PAINT_Y_WIDTH 7

// Width of the house table index and of the LFSR that produces it
`define PAINT_HOUSE_IDX_WIDTH 4

// Boxes are square with an edge of 2**PAINT_BOX_SIDE_LOG2 pixels
`define PAINT_BOX_SIDE_LOG2 2

// Number of boxes drawn for one go request
`define PAINT_BOXES_PER_RUN 15

// LFSR value after reset, it must be nonzero
`define PAINT_LFSR_SEED 4'b0001

`endif

// File: painter_pkg.sv
`default_nettype none

`include "painter_config.svh"

package painter_pkg;

	// Counter must hold every value up to PAINT_BOXES_PER_RUN
	localparam int BOX_COUNT_WIDTH = $clog2(`PAINT_BOXES_PER_RUN + 1);

	typedef logic [`PAINT_X_WIDTH-1:0] coord_x_t;
	typedef logic [`PAINT_Y_WIDTH-1:0] coord_y_t;
	typedef logic [`PAINT_HOUSE_IDX_WIDTH-1:0] house_idx_t;
	typedef logic [2*`PAINT_BOX_SIDE_LOG2-1:0] box_pixel_t; // Row offset in the high half
	typedef logic [BOX_COUNT_WIDTH-1:0] box_count_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,      // Waiting for the first go
		SEQ_START_BOX, // One cycle that issues box_start
		SEQ_WAIT_BOX,  // Drawer is busy with the current box
		SEQ_FINISHED   // Run complete, done_out held high
	} seq_state_t;

	typedef enum logic [1:0] {
		DRAW_IDLE,
		DRAW_PLOTTING, // One pixel per cycle
		DRAW_ENDING    // Box finished, box_done high
	} draw_state_t;

endpackage

`default_nettype wire

// File: house_picker.sv
`default_nettype none

`include "painter_config.svh"

module house_picker import painter_pkg::*; (
	input  logic     clk,
	input  logic     resetn,
	input  logic     next_house, // Step the LFSR on this edge
	output coord_x_t origin_x,
	output coord_y_t origin_y
);

	house_idx_t lfsr; // Current table index

	// Fibonacci LFSR with taps on bits 3 and 2 and a period of 15
	// The all-zero state is never entered from a nonzero seed
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			lfsr <= `PAINT_LFSR_SEED;
		end else if (next_house) begin
			lfsr <= {lfsr[`PAINT_HOUSE_IDX_WIDTH-2:0], lfsr[3] ^ lfsr[2]}; // Shift left
		end
	end

	// House origin table, read combinationally from the current index
	always_comb begin
		case (lfsr)
			4'd0:  begin origin_x = 8'd4;   origin_y = 7'd4;   end
			4'd1:  begin origin_x = 8'd4;   origin_y = 7'd36;  end
			4'd2:  begin origin_x = 8'd4;   origin_y = 7'd68;  end // First box after reset
			4'd3:  begin origin_x = 8'd4;   origin_y = 7'd100; end
			4'd4:  begin origin_x = 8'd36;  origin_y = 7'd4;   end
			4'd5:  begin origin_x = 8'd52;  origin_y = 7'd36;  end
			4'd6:  begin origin_x = 8'd52;  origin_y = 7'd68;  end
			4'd7:  begin origin_x = 8'd52;  origin_y = 7'd100; end
			4'd8:  begin origin_x = 8'd68;  origin_y = 7'd4;   end
			4'd9:  begin origin_x = 8'd100; origin_y = 7'd36;  end
			4'd10: begin origin_x = 8'd100; origin_y = 7'd68;  end
			4'd11: begin origin_x = 8'd100; origin_y = 7'd100; end
			4'd12: begin origin_x = 8'd100; origin_y = 7'd4;   end
			4'd13: begin origin_x = 8'd148; origin_y = 7'd36;  end
			4'd14: begin origin_x = 8'd148; origin_y = 7'd68;  end
			4'd15: begin origin_x = 8'd148; origin_y = 7'd100; end
			default: begin // Only reachable with unknown index bits
				origin_x = 8'd4;
				origin_y = 7'd4;
			end
		endcase
	end

	// Zero would lock the LFSR and repeat one house forever
	a_lfsr_nonzero: assert property (@(posedge clk) disable iff (!resetn)
		lfsr != '0)
		else $error("house_picker LFSR reached the all-zero state");

endmodule

`default_nettype wire

// File: box_drawer.sv
`default_nettype none

`include "painter_config.svh"

module box_drawer import painter_pkg::*; (
	input  logic     clk,
	input  logic     resetn,
	input  logic     box_start, // One-cycle pulse, origin is sampled on this edge
	input  coord_x_t origin_x,
	input  coord_y_t origin_y,
	output coord_x_t x,
	output coord_y_t y,
	output logic     plot,
	output logic     box_done   // One cycle after the last pixel
);

	localparam int SIDE = `PAINT_BOX_SIDE_LOG2;

	draw_state_t state;
	box_pixel_t  pix;   // Index of the pixel that goes out on the next edge
	coord_x_t    org_x; // Latched box origin
	coord_y_t    org_y;
	logic        last_shown; // Pixel 15 is on the outputs now

	// The counter has wrapped, so every pixel has been presented
	assign last_shown = (pix == '0);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= DRAW_IDLE;
			pix   <= '0;
		end else begin
			case (state)
				DRAW_IDLE: if (box_start) begin
					state <= DRAW_PLOTTING;
					pix   <= box_pixel_t'(1); // Pixel 0 is loaded straight from the origin
				end
				DRAW_PLOTTING: begin
					pix <= pix + box_pixel_t'(1);
					if (last_shown) state <= DRAW_ENDING;
				end
				DRAW_ENDING: state <= DRAW_IDLE;
				default: state <= DRAW_IDLE;
			endcase
		end
	end

	// Origin latch and pixel position, both pure payload
	always_ff @(posedge clk) begin
		if (state == DRAW_IDLE && box_start) begin
			org_x <= origin_x;
			org_y <= origin_y;
			x     <= origin_x;
			y     <= origin_y;
		end else if (state == DRAW_PLOTTING && !last_shown) begin
			x <= org_x + coord_x_t'(pix[SIDE-1:0]);      // Column offset runs fastest
			y <= org_y + coord_y_t'(pix[2*SIDE-1:SIDE]); // Row offset
		end
	end

	// Both decode the state register so they line up with x and y
	assign plot     = (state == DRAW_PLOTTING);
	assign box_done = (state == DRAW_ENDING);

	// The sequencer must wait for box_done before starting the next box
	a_start_when_idle: assert property (@(posedge clk) disable iff (!resetn)
		box_start |-> state == DRAW_IDLE)
		else $error("box_drawer got box_start while busy");

	// plot stays high for the whole box once started
	a_plot_length: assert property (@(posedge clk) disable iff (!resetn)
		(state == DRAW_IDLE && box_start) |=> plot [*(1 << (2*SIDE))] ##1 box_done)
		else $error("box_drawer did not plot a full box");

endmodule

`default_nettype wire

// File: run_sequencer.sv
`default_nettype none

`include "painter_config.svh"

module run_sequencer import painter_pkg::*; (
	input  logic clk,
	input  logic resetn,
	input  logic go,         // Start request, level
	input  logic box_done,   // Pulse from the drawer
	output logic box_start,  // Pulse to the drawer
	output logic next_house, // Pulse to the picker, one per box
	output logic done_out    // High from end of run until the next go
);

	seq_state_t state;
	seq_state_t state_nxt;
	box_count_t box_count; // Boxes finished in this run
	logic       launch;    // go accepted in this cycle
	logic       last_box;  // The box in progress is the final one

	assign launch   = go && (state == SEQ_IDLE || state == SEQ_FINISHED);
	assign last_box = (box_count == box_count_t'(`PAINT_BOXES_PER_RUN - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			SEQ_IDLE, SEQ_FINISHED: if (go) state_nxt = SEQ_START_BOX;
			SEQ_START_BOX: state_nxt = SEQ_WAIT_BOX; // Drawer is now busy
			SEQ_WAIT_BOX: if (box_done) begin
				state_nxt = last_box ? SEQ_FINISHED : SEQ_START_BOX;
			end
			default: state_nxt = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state     <= SEQ_IDLE;
			box_count <= '0;
		end else begin
			state <= state_nxt;
			if (launch) begin
				box_count <= '0; // Each run starts from zero boxes
			end else if (state == SEQ_WAIT_BOX && box_done) begin
				box_count <= box_count + box_count_t'(1);
			end
		end
	end

	// The picker steps in the cycle before every box_start so the drawer
	// latches a fresh origin, the LFSR keeps running across runs
	assign next_house = launch || (state == SEQ_WAIT_BOX && box_done && !last_box);

	assign box_start = (state == SEQ_START_BOX);
	assign done_out  = (state == SEQ_FINISHED);

	// No new box may be started once the run is reported done
	a_start_not_done: assert property (@(posedge clk) disable iff (!resetn)
		!(box_start && done_out))
		else $error("run_sequencer started a box while done_out is high");

endmodule

`default_nettype wire

// File: random_painting.sv
`default_nettype none

module random_painting import painter_pkg::*; (
	input  logic     clk,
	input  logic     resetn,
	input  logic     go,       // Start a run of boxes
	output coord_x_t x,        // Pixel position, valid while plot is high
	output coord_y_t y,
	output logic     plot,
	output logic     done_out  // Rises when the run is complete
);

	coord_x_t origin_x; // Current house origin from the picker
	coord_y_t origin_y;
	logic     next_house;
	logic     box_start;
	logic     box_done;

	house_picker u_picker (
		.clk        (clk),
		.resetn     (resetn),
		.next_house (next_house),
		.origin_x   (origin_x),
		.origin_y   (origin_y)
	);

	run_sequencer u_sequencer (
		.clk        (clk),
		.resetn     (resetn),
		.go         (go),
		.box_done   (box_done),
		.box_start  (box_start),
		.next_house (next_house),
		.done_out   (done_out)
	);

	box_drawer u_drawer (
		.clk       (clk),
		.resetn    (resetn),
		.box_start (box_start),
		.origin_x  (origin_x),
		.origin_y  (origin_y),
		.x         (x),
		.y         (y),
		.plot      (plot),
		.box_done  (box_done)
	);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 40, // Clock period in time units
	parameter int RESET_CYCLES = 16  // Rising edges with resetn held low
) (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Release lands a little after a rising edge, clear of the sampling point
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 resetn = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb_random_painting.sv
`default_nettype none

`include "painter_config.svh"

module tb_random_painting import painter_pkg::*; ();

	localparam int DRIVE_DELAY    = 2;   // Inputs change this long after a rising edge
	localparam int EDGE           = 1 << `PAINT_BOX_SIDE_LOG2; // Pixels along one box edge
	localparam int PIX_PER_BOX    = EDGE * EDGE;
	localparam int PIXELS_PER_RUN = `PAINT_BOXES_PER_RUN * PIX_PER_BOX;
	localparam int RUNS           = 3;   // Three runs walk the LFSR well past one period
	localparam int RUN_TIMEOUT    = 2000;
	localparam int RESET_TIMEOUT  = 100;

	logic       clk;
	logic       resetn;
	logic       go;
	coord_x_t   x;
	coord_y_t   y;
	logic       plot;
	logic       done_out;
	logic [31:0] rng = 32'hd8ed; // Galois LFSR state for idle gaps
	int         pix_total = 0;   // Pixels plotted since reset over all runs
	int         start_count;
	coord_x_t   exp_x;
	coord_y_t   exp_y;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(16)) u_clock (.clk(clk), .resetn(resetn));

	random_painting dut0 (
		.clk      (clk),
		.resetn   (resetn),
		.go       (go),
		.x        (x),
		.y        (y),
		.plot     (plot),
		.done_out (done_out)
	);

	// Right shifting Galois form with taps 32, 22, 2 and 1
	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int random_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(rng[0]); // One step for every bit taken
			rng = galois_step(rng);
		end
		return value;
	endfunction

	// Index register after a number of steps from the seed
	function automatic house_idx_t house_after_steps(input int steps);
		house_idx_t s;
		s = `PAINT_LFSR_SEED;
		for (int i = 0; i < steps; i++) begin
			s = {s[2:0], s[3] ^ s[2]};
		end
		return s;
	endfunction

	// House table with x in the upper bits and y in the lower ones
	function automatic logic [`PAINT_X_WIDTH+`PAINT_Y_WIDTH-1:0] house_origin(input house_idx_t idx);
		case (idx)
			4'd0:  return {8'd4, 7'd4};
			4'd1:  return {8'd4, 7'd36};
			4'd2:  return {8'd4, 7'd68};
			4'd3:  return {8'd4, 7'd100};
			4'd4:  return {8'd36, 7'd4};
			4'd5:  return {8'd52, 7'd36};
			4'd6:  return {8'd52, 7'd68};
			4'd7:  return {8'd52, 7'd100};
			4'd8:  return {8'd68, 7'd4};
			4'd9:  return {8'd100, 7'd36};
			4'd10: return {8'd100, 7'd68};
			4'd11: return {8'd100, 7'd100};
			4'd12: return {8'd100, 7'd4};
			4'd13: return {8'd148, 7'd36};
			4'd14: return {8'd148, 7'd68};
			default: return {8'd148, 7'd100};
		endcase
	endfunction

	// Reference model for the position of the n-th plotted pixel since reset
	function automatic void expected_pixel(input int n, output coord_x_t ex, output coord_y_t ey);
		int box;
		int p;
		logic [`PAINT_X_WIDTH+`PAINT_Y_WIDTH-1:0] org;
		box = n / PIX_PER_BOX;
		p   = n % PIX_PER_BOX;
		org = house_origin(house_after_steps(box + 1)); // Every box is preceded by one step
		ex  = org[`PAINT_X_WIDTH+`PAINT_Y_WIDTH-1:`PAINT_Y_WIDTH] + coord_x_t'(p % EDGE);
		ey  = org[`PAINT_Y_WIDTH-1:0] + coord_y_t'(p / EDGE); // Row advances after a full line
	endfunction

	task automatic stop_on_failure();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_x(input string name, input coord_x_t expected, input coord_x_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %0d actual %0d", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_y(input string name, input coord_y_t expected, input coord_y_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %0d actual %0d", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s expected %b actual %b", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERR %s expected %0d actual %0d", name, expected, actual);
			stop_on_failure();
		end
	endtask

	// Monitor samples on the falling edge half a period away from any update
	always @(negedge clk) begin
		if (resetn) begin
			check_flag("plot while done", 1'b0, plot && done_out);
			if (plot) begin
				expected_pixel(pix_total, exp_x, exp_y);
				check_x($sformatf("pixel %0d x", pix_total), exp_x, x);
				check_y($sformatf("pixel %0d y", pix_total), exp_y, y);
				pix_total++;
			end
		end
	end

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (resetn !== 1'b1) begin
			@(negedge clk);
			if (resetn !== 1'b1) begin
				check_flag("plot in reset", 1'b0, plot);
				check_flag("done in reset", 1'b0, done_out);
			end
			cycles++;
			if (cycles > RESET_TIMEOUT) begin
				$display("Timeout: resetn was never released");
				stop_on_failure();
			end
		end
	endtask

	// Quiet stretch with go low where done_out must keep its level
	task automatic idle_window(input int cycles, input logic done_level);
		repeat (cycles) begin
			@(negedge clk);
			check_flag("plot while idle", 1'b0, plot);
			check_flag("done while idle", done_level, done_out);
		end
	endtask

	task automatic pulse_go();
		@(posedge clk);
		#DRIVE_DELAY go = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY go = 1'b0; // Sequencer has left idle or finished on this edge
	endtask

	task automatic wait_done_rise(input int limit);
		int cycles;
		cycles = 0;
		while (!done_out) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: done_out did not rise within %0d cycles", limit);
				stop_on_failure();
			end
		end
	endtask

	initial begin
		go = 1'b0;
		wait_reset_release();
		idle_window(1 + random_bits(5), 1'b0); // Nothing happens before the first go
		for (int run = 0; run < RUNS; run++) begin
			start_count = pix_total;
			pulse_go();
			@(negedge clk);
			check_flag($sformatf("run %0d done cleared", run), 1'b0, done_out);
			wait_done_rise(RUN_TIMEOUT);
			check_count($sformatf("run %0d pixels", run), PIXELS_PER_RUN, pix_total - start_count);
			idle_window(2 + random_bits(5), 1'b1); // done_out holds until the next go
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
painter_pkg.sv
house_picker.sv
box_drawer.sv
run_sequencer.sv
random_painting.sv
tb_clock_gen.sv
tb_random_painting.sv

// File: Bender.yml
package:
  name: random_painting

sources:
  - include_dirs:
      - .
    files:
      - painter_pkg.sv
      - house_picker.sv
      - box_drawer.sv
      - run_sequencer.sv
      - random_painting.sv
      - target: simulation
        files:
          - tb_clock_gen.sv
          - tb_random_painting.sv
